// File: rtl/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// ==============================
// core sizing
// ==============================

// data and address width, one word
`define MIPS_XLEN 32

// architectural register count
`define MIPS_NREGS 32

// register index width
`define MIPS_RADDR_W 5

// data memory word address width
// word address taken from alu result bits 8 down to 2
`define MIPS_DMEM_AW 7

`endif

// File: rtl/mipsPkg.sv
`include "mips_cfg.svh"

package mipsPkg;

  // ==============================
  // instruction encodings
  // ==============================

  // major opcodes, bits 31:26
  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_JAL   = 6'h03,
    OP_BEQ   = 6'h04,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } opcode_e;

  // r-type function codes, bits 5:0
  typedef enum logic [5:0] {
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_SLT = 6'h2a
  } funct_e;

  // one instruction word, three field layouts
  typedef union packed {
    struct packed {
      logic [5:0]                 opcode;
      logic [`MIPS_RADDR_W-1:0]   rs;
      logic [`MIPS_RADDR_W-1:0]   rt;
      logic [`MIPS_RADDR_W-1:0]   rd;
      logic [4:0]                 shamt;
      logic [5:0]                 funct;
    } rType;
    struct packed {
      logic [5:0]                 opcode;
      logic [`MIPS_RADDR_W-1:0]   rs;
      logic [`MIPS_RADDR_W-1:0]   rt;
      logic [15:0]                imm16;
    } iType;
    struct packed {
      logic [5:0]                 opcode;
      logic [25:0]                target26;
    } jType;
  } instr_t;

  // ==============================
  // datapath control
  // ==============================

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } aluOp_e;

  // per-instruction steering bits
  typedef struct packed {
    logic regDst;
    logic aluSrc;
    logic memToReg;
    logic regWrite;
    logic memWrite;
    logic branch;
    logic jump;
    logic link;
  } ctrl_t;

  // register write-back bundle
  typedef struct packed {
    logic                     enable;
    logic [`MIPS_RADDR_W-1:0] addr;
    logic [`MIPS_XLEN-1:0]    data;
  } wb_t;

endpackage

// File: rtl/mainDecoder.sv
`timescale 1ns/10ps
`include "mips_cfg.svh"

module mainDecoder (
  input  mipsPkg::instr_t       instr,
  output mipsPkg::ctrl_t        ctrl,
  output mipsPkg::aluOp_e       aluOp,
  output logic [`MIPS_XLEN-1:0] immExt
);

  // ==============================
  // immediate
  // ==============================

  // sign extend imm16, also feeds the branch offset
  assign immExt = {{(`MIPS_XLEN-16){instr.iType.imm16[15]}}, instr.iType.imm16};

  // ==============================
  // opcode and funct decode
  // ==============================

  always_comb begin
    // default is a no-op, nothing written anywhere
    ctrl  = '0;
    aluOp = mipsPkg::ALU_ADD;

    case (instr.rType.opcode)
      mipsPkg::OP_RTYPE: begin
        ctrl.regDst = 1'b1;
        // only known function codes write rd
        case (instr.rType.funct)
          mipsPkg::FN_ADD: begin
            aluOp         = mipsPkg::ALU_ADD;
            ctrl.regWrite = 1'b1;
          end
          mipsPkg::FN_SUB: begin
            aluOp         = mipsPkg::ALU_SUB;
            ctrl.regWrite = 1'b1;
          end
          mipsPkg::FN_AND: begin
            aluOp         = mipsPkg::ALU_AND;
            ctrl.regWrite = 1'b1;
          end
          mipsPkg::FN_OR: begin
            aluOp         = mipsPkg::ALU_OR;
            ctrl.regWrite = 1'b1;
          end
          mipsPkg::FN_SLT: begin
            aluOp         = mipsPkg::ALU_SLT;
            ctrl.regWrite = 1'b1;
          end
          // unknown funct, falls through as no-op
          default: ctrl.regWrite = 1'b0;
        endcase
      end
      mipsPkg::OP_LW: begin
        // address = rs + imm
        ctrl.aluSrc   = 1'b1;
        ctrl.memToReg = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      mipsPkg::OP_SW: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
      end
      mipsPkg::OP_BEQ: begin
        // equality via subtract and zero flag
        aluOp       = mipsPkg::ALU_SUB;
        ctrl.branch = 1'b1;
      end
      mipsPkg::OP_J: begin
        ctrl.jump = 1'b1;
      end
      mipsPkg::OP_JAL: begin
        // link into r31
        ctrl.jump     = 1'b1;
        ctrl.link     = 1'b1;
        ctrl.regWrite = 1'b1;
      end
      default: ctrl = '0;
    endcase
  end

endmodule

// File: rtl/regFile.sv
`timescale 1ns/10ps
`include "mips_cfg.svh"

module regFile (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [`MIPS_RADDR_W-1:0] rs,
  input  logic [`MIPS_RADDR_W-1:0] rt,
  input  mipsPkg::wb_t             wb,
  output logic [`MIPS_XLEN-1:0]    rsData,
  output logic [`MIPS_XLEN-1:0]    rtData
);

  // ==============================
  // register array
  // ==============================

  logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS];

  // single write port at the clock edge
  // enable already excludes r0
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < `MIPS_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.enable) begin
      regs[wb.addr] <= wb.data;
    end
  end

  // ==============================
  // read ports
  // ==============================

  // combinational, r0 hardwired to zero
  assign rsData = (rs == '0) ? '0 : regs[rs];
  assign rtData = (rt == '0) ? '0 : regs[rt];

endmodule

// File: rtl/alu.sv
`timescale 1ns/10ps
`include "mips_cfg.svh"

module alu (
  input  logic [`MIPS_XLEN-1:0] opA,
  input  logic [`MIPS_XLEN-1:0] rtData,
  input  logic [`MIPS_XLEN-1:0] immExt,
  input  logic                  aluSrc,
  input  mipsPkg::aluOp_e       aluOp,
  output logic [`MIPS_XLEN-1:0] result,
  output logic                  zero
);

  // ==============================
  // operand select
  // ==============================

  logic [`MIPS_XLEN-1:0] opB;

  // immediate for lw/sw, register otherwise
  assign opB = aluSrc ? immExt : rtData;

  // ==============================
  // operations
  // ==============================

  always_comb begin
    case (aluOp)
      mipsPkg::ALU_ADD: result = opA + opB;
      mipsPkg::ALU_SUB: result = opA - opB;
      mipsPkg::ALU_AND: result = opA & opB;
      mipsPkg::ALU_OR:  result = opA | opB;
      // signed compare, result is 0 or 1
      mipsPkg::ALU_SLT: begin
        result = ($signed(opA) < $signed(opB)) ? 1 : 0;
      end
      default: result = '0;
    endcase
  end

  // zero flag drives the beq decision
  assign zero = (result == '0);

endmodule

// File: rtl/pcUnit.sv
`timescale 1ns/10ps
`include "mips_cfg.svh"

module pcUnit (
  input  logic                  clk,
  input  logic                  rst,
  input  mipsPkg::instr_t       instr,
  input  mipsPkg::ctrl_t        ctrl,
  input  logic [`MIPS_XLEN-1:0] immExt,
  input  logic                  zero,
  output logic [`MIPS_XLEN-1:0] pc,
  output logic [`MIPS_XLEN-1:0] pcPlus4
);

  logic [`MIPS_XLEN-1:0] branchTarget;
  logic [`MIPS_XLEN-1:0] jumpTarget;
  logic                  takeBranch;

  // ==============================
  // next-pc candidates
  // ==============================

  assign pcPlus4 = pc + 'd4;

  // word offset, shifted left by two
  assign branchTarget = pcPlus4 + (immExt << 2);

  // region bits kept from pc + 4
  assign jumpTarget = {pcPlus4[`MIPS_XLEN-1 -: 4], instr.jType.target26, 2'b00};

  assign takeBranch = ctrl.branch & zero;

  // jump wins over branch
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else if (ctrl.jump) begin
      pc <= jumpTarget;
    end else if (takeBranch) begin
      pc <= branchTarget;
    end else begin
      pc <= pcPlus4;
    end
  end

endmodule

// File: rtl/singleCycleMips.sv
`timescale 1ns/10ps
`include "mips_cfg.svh"

module singleCycleMips (
  input  logic                     clk,
  input  logic                     rst,
  // instruction memory
  output logic [`MIPS_XLEN-1:0]    imemAddr,
  input  mipsPkg::instr_t          instr,
  // data memory, word addressed
  output logic [`MIPS_DMEM_AW-1:0] dmemAddr,
  output logic [`MIPS_XLEN-1:0]    dmemWdata,
  output logic                     dmemWrite,
  input  logic [`MIPS_XLEN-1:0]    dmemRdata,
  // write-back observation
  output mipsPkg::wb_t             wb
);

  mipsPkg::ctrl_t        ctrl;
  mipsPkg::aluOp_e       aluOp;
  logic [`MIPS_XLEN-1:0] immExt;
  logic [`MIPS_XLEN-1:0] rsData;
  logic [`MIPS_XLEN-1:0] rtData;
  logic [`MIPS_XLEN-1:0] aluResult;
  logic                  zero;
  logic [`MIPS_XLEN-1:0] pc;
  logic [`MIPS_XLEN-1:0] pcPlus4;

  // ==============================
  // datapath blocks
  // ==============================

  mainDecoder i_mainDecoder (
    .instr  (instr),
    .ctrl   (ctrl),
    .aluOp  (aluOp),
    .immExt (immExt)
  );

  // read ports straight from rs and rt
  regFile i_regFile (
    .clk    (clk),
    .rst    (rst),
    .rs     (instr.rType.rs),
    .rt     (instr.rType.rt),
    .wb     (wb),
    .rsData (rsData),
    .rtData (rtData)
  );

  alu i_alu (
    .opA    (rsData),
    .rtData (rtData),
    .immExt (immExt),
    .aluSrc (ctrl.aluSrc),
    .aluOp  (aluOp),
    .result (aluResult),
    .zero   (zero)
  );

  pcUnit i_pcUnit (
    .clk     (clk),
    .rst     (rst),
    .instr   (instr),
    .ctrl    (ctrl),
    .immExt  (immExt),
    .zero    (zero),
    .pc      (pc),
    .pcPlus4 (pcPlus4)
  );

  // ==============================
  // write-back and memory ports
  // ==============================

  // dest mux: rd, r31 on link, else rt
  // data mux: load data, return address, else alu
  always_comb begin
    if (ctrl.regDst) begin
      wb.addr = instr.rType.rd;
    end else if (ctrl.link) begin
      wb.addr = `MIPS_RADDR_W'(`MIPS_NREGS - 1);
    end else begin
      wb.addr = instr.rType.rt;
    end

    if (ctrl.memToReg) begin
      wb.data = dmemRdata;
    end else if (ctrl.link) begin
      wb.data = pcPlus4;
    end else begin
      wb.data = aluResult;
    end

    // writes to r0 are dropped here
    wb.enable = ctrl.regWrite && (wb.addr != '0);
  end

  assign imemAddr = pc;

  // byte address to word address
  assign dmemAddr  = aluResult[`MIPS_DMEM_AW+1:2];
  assign dmemWdata = rtData;
  assign dmemWrite = ctrl.memWrite;

endmodule

// File: test/singleCycleMips_assertions.sv
`timescale 1ns/10ps
`include "mips_cfg.svh"

module singleCycleMips_assertions (
  input logic                  clk,
  input logic                  rst,
  input logic [`MIPS_XLEN-1:0] imemAddr,
  input logic                  dmemWrite,
  input mipsPkg::wb_t          wb
);

  // number of failed checks
  int failCount = 0;

  // ==============================
  // port rules
  // ==============================

  // fetch always on a word boundary
  assert property (@(posedge clk) disable iff (!rst) imemAddr[1:0] == 2'b00)
    else begin
      failCount++;
      $error("imemAddr not word aligned");
    end

  // no instruction both loads a register and stores
  assert property (@(posedge clk) disable iff (!rst) !(wb.enable && dmemWrite))
    else begin
      failCount++;
      $error("wb.enable and dmemWrite both high");
    end

  assert property (@(posedge clk) disable iff (!rst) wb.enable |-> wb.addr != '0)
    else begin
      failCount++;
      $error("write-back to r0");
    end

  // first fetch after reset from address 0
  assert property (@(posedge clk) $rose(rst) |-> imemAddr == '0)
    else begin
      failCount++;
      $error("imemAddr not 0 after reset release");
    end

endmodule

bind singleCycleMips singleCycleMips_assertions i_singleCycleMips_assertions (
  .clk       (clk),
  .rst       (rst),
  .imemAddr  (imemAddr),
  .dmemWrite (dmemWrite),
  .wb        (wb)
);

// File: test/singleCycleMipsTb.sv
`timescale 1ns/10ps
`include "mips_cfg.svh"

module singleCycleMipsTb;

  localparam int IMEM_WORDS = 64;
  localparam int DMEM_WORDS = 1 << `MIPS_DMEM_AW;

  logic                     clk;
  logic                     rst;
  logic [`MIPS_XLEN-1:0]    imemAddr;
  mipsPkg::instr_t          instr;
  logic [`MIPS_DMEM_AW-1:0] dmemAddr;
  logic [`MIPS_XLEN-1:0]    dmemWdata;
  logic                     dmemWrite;
  logic [`MIPS_XLEN-1:0]    dmemRdata;
  mipsPkg::wb_t             wb;

  // memory models around the core
  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] dmem [DMEM_WORDS];
  logic        loadNow;

  // reference model state
  logic [31:0] modelRegs [`MIPS_NREGS];
  logic [31:0] modelMem [DMEM_WORDS];
  logic [31:0] modelPc;

  // image for the next program
  logic [31:0] progQ [$];
  logic [31:0] dataInit [DMEM_WORDS];

  // expected response of the current instruction
  logic        expEn;
  logic [4:0]  expAddr;
  logic [31:0] expData;
  logic        expMemWr;
  logic [6:0]  expMemIdx;
  logic [31:0] expMemData;
  logic [31:0] expNextPc;

  integer seed;

  singleCycleMips i_singleCycleMips (
    .clk       (clk),
    .rst       (rst),
    .imemAddr  (imemAddr),
    .instr     (instr),
    .dmemAddr  (dmemAddr),
    .dmemWdata (dmemWdata),
    .dmemWrite (dmemWrite),
    .dmemRdata (dmemRdata),
    .wb        (wb)
  );

  // ==============================
  // clock and memories
  // ==============================

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // all-zero word while in reset, decodes as a no-op
  assign instr     = rst ? imem[imemAddr[7:2]] : '0;
  assign dmemRdata = dmem[dmemAddr];

  // image load during reset, store on the edge otherwise
  always @(posedge clk) begin
    if (loadNow) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        dmem[i] <= dataInit[i];
      end
    end else if (dmemWrite) begin
      dmem[dmemAddr] <= dmemWdata;
    end
  end

  // a failed bound assertion ends the run
  always @(negedge clk) begin
    if (i_singleCycleMips.i_singleCycleMips_assertions.failCount != 0) begin
      $display("a port assertion on the core failed");
      $display("TEST FAILED");
      $fatal(1, "assertion failed");
    end
  end

  // ==============================
  // encoders, model, checks
  // ==============================

  function automatic logic [31:0] rInstr(input logic [5:0] fn, input logic [4:0] rd,
                                         input logic [4:0] rs, input logic [4:0] rt);
    return {6'h00, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] iInstr(input logic [5:0] op, input logic [4:0] rs,
                                         input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] jInstr(input logic [5:0] op, input logic [25:0] target);
    return {op, target};
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s is %h, expected %h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // isa rules for one instruction at modelPc
  task automatic predict(input logic [31:0] iw);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] seq;
    logic [31:0] ea;
    a          = modelRegs[iw[25:21]];
    b          = modelRegs[iw[20:16]];
    imm        = {{16{iw[15]}}, iw[15:0]};
    seq        = modelPc + 32'd4;
    ea         = a + imm;
    expEn      = 1'b0;
    expAddr    = iw[20:16];
    expData    = '0;
    expMemWr   = 1'b0;
    expMemIdx  = ea[8:2];
    expMemData = b;
    expNextPc  = seq;
    case (iw[31:26])
      mipsPkg::OP_RTYPE: begin
        expAddr = iw[15:11];
        expEn   = 1'b1;
        case (iw[5:0])
          mipsPkg::FN_ADD: expData = a + b;
          mipsPkg::FN_SUB: expData = a - b;
          mipsPkg::FN_AND: expData = a & b;
          mipsPkg::FN_OR:  expData = a | b;
          mipsPkg::FN_SLT: expData = {31'd0, $signed(a) < $signed(b)};
          default:         expEn = 1'b0;
        endcase
      end
      mipsPkg::OP_LW: begin
        expEn   = 1'b1;
        expData = modelMem[expMemIdx];
      end
      mipsPkg::OP_SW:  expMemWr = 1'b1;
      mipsPkg::OP_BEQ: begin
        if (a == b) begin
          expNextPc = seq + (imm << 2);
        end
      end
      mipsPkg::OP_J:   expNextPc = {seq[31:28], iw[25:0], 2'b00};
      mipsPkg::OP_JAL: begin
        expEn     = 1'b1;
        expAddr   = 5'd31;
        expData   = seq;
        expNextPc = {seq[31:28], iw[25:0], 2'b00};
      end
      default: expEn = 1'b0;
    endcase
    // r0 never written
    expEn = expEn && (expAddr != 5'd0);
  endtask

  // sampled mid-cycle, outputs settled
  task automatic stepAndCheck();
    logic [31:0] iw;
    iw = imem[modelPc[7:2]];
    compare("imemAddr", imemAddr, modelPc);
    predict(iw);
    compare("wb.enable", wb.enable, expEn);
    if (expEn) begin
      compare("wb.addr", wb.addr, expAddr);
      compare("wb.data", wb.data, expData);
      modelRegs[expAddr] = expData;
    end
    compare("dmemWrite", dmemWrite, expMemWr);
    if (expMemWr) begin
      compare("dmemAddr", dmemAddr, expMemIdx);
      compare("dmemWdata", dmemWdata, expMemData);
      modelMem[expMemIdx] = expMemData;
    end
    modelPc = expNextPc;
  endtask

  task automatic newImage();
    progQ = {};
    for (int i = 0; i < DMEM_WORDS; i++) begin
      // each word tagged with its index
      dataInit[i] = 32'hda7a_0000 | (i * 32'h0000_0101);
    end
  endtask

  // reset, load, run until pc leaves the program, then compare memory
  task automatic runProgram(input int maxCycles);
    logic [31:0] endAddr;
    int          cycles;
    endAddr = progQ.size() * 4;
    @(posedge clk);
    rst <= 1'b0;
    repeat (15) @(posedge clk);
    for (int i = 0; i < IMEM_WORDS; i++) begin
      // unknown opcode 0x3f past the program end
      imem[i] = (i < progQ.size()) ? progQ[i] : {6'h3f, 20'd0, 6'(i)};
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      modelMem[i] = dataInit[i];
    end
    for (int i = 0; i < `MIPS_NREGS; i++) begin
      modelRegs[i] = '0;
    end
    modelPc = '0;
    loadNow <= 1'b1;
    @(posedge clk);
    loadNow <= 1'b0;
    rst     <= 1'b1;
    cycles = 0;
    while (modelPc != endAddr) begin
      if (cycles >= maxCycles) begin
        $display("timeout: pc did not reach %h within %0d cycles", endAddr, maxCycles);
        $display("TEST FAILED");
        $fatal(1, "program did not finish");
      end else begin
        @(negedge clk);
        stepAndCheck();
        cycles++;
      end
    end
    @(negedge clk);
    for (int i = 0; i < DMEM_WORDS; i++) begin
      compare($sformatf("dmem[%0d]", i), dmem[i], modelMem[i]);
    end
  endtask

  // ==============================
  // directed tests
  // ==============================

  task automatic arithmeticOps();
    newImage();
    dataInit[0] = $random(seed);
    dataInit[1] = $random(seed);
    dataInit[2] = $random(seed) | 32'h8000_0000;
    dataInit[3] = $random(seed) & 32'h7fff_ffff;
    for (int r = 1; r <= 4; r++) begin
      progQ.push_back(iInstr(mipsPkg::OP_LW, 5'd0, 5'(r), 16'(4 * (r - 1))));
    end
    progQ.push_back(rInstr(mipsPkg::FN_ADD, 5'd5, 5'd1, 5'd2));
    progQ.push_back(rInstr(mipsPkg::FN_SUB, 5'd6, 5'd1, 5'd2));
    progQ.push_back(rInstr(mipsPkg::FN_AND, 5'd7, 5'd1, 5'd2));
    progQ.push_back(rInstr(mipsPkg::FN_OR, 5'd8, 5'd1, 5'd2));
    // negative against positive, both ways
    progQ.push_back(rInstr(mipsPkg::FN_SLT, 5'd9, 5'd3, 5'd4));
    progQ.push_back(rInstr(mipsPkg::FN_SLT, 5'd10, 5'd4, 5'd3));
    progQ.push_back(rInstr(mipsPkg::FN_SLT, 5'd11, 5'd1, 5'd2));
    progQ.push_back(rInstr(mipsPkg::FN_SUB, 5'd12, 5'd3, 5'd4));
    progQ.push_back(rInstr(mipsPkg::FN_ADD, 5'd13, 5'd5, 5'd6));
    progQ.push_back(iInstr(mipsPkg::OP_SW, 5'd0, 5'd13, 16'd16));
    runProgram(2 * progQ.size() + 8);
  endtask

  task automatic loadStore();
    newImage();
    dataInit[0] = $random(seed);
    dataInit[1] = 32'h0000_0040;
    progQ.push_back(iInstr(mipsPkg::OP_LW, 5'd0, 5'd1, 16'd0));
    progQ.push_back(iInstr(mipsPkg::OP_LW, 5'd0, 5'd2, 16'd4));
    progQ.push_back(iInstr(mipsPkg::OP_SW, 5'd2, 5'd1, 16'd8));
    progQ.push_back(iInstr(mipsPkg::OP_LW, 5'd2, 5'd3, 16'd8));
    // offset -4 from base 0x40
    progQ.push_back(iInstr(mipsPkg::OP_SW, 5'd2, 5'd3, 16'hfffc));
    progQ.push_back(iInstr(mipsPkg::OP_LW, 5'd0, 5'd4, 16'd60));
    progQ.push_back(iInstr(mipsPkg::OP_SW, 5'd0, 5'd2, 16'd100));
    progQ.push_back(iInstr(mipsPkg::OP_LW, 5'd0, 5'd5, 16'd100));
    runProgram(2 * progQ.size() + 8);
  endtask

  task automatic branches();
    newImage();
    dataInit[0] = $random(seed);
    dataInit[1] = ~dataInit[0];
    progQ.push_back(iInstr(mipsPkg::OP_LW, 5'd0, 5'd1, 16'd0));
    progQ.push_back(iInstr(mipsPkg::OP_LW, 5'd0, 5'd2, 16'd0));
    progQ.push_back(iInstr(mipsPkg::OP_LW, 5'd0, 5'd3, 16'd4));
    progQ.push_back(iInstr(mipsPkg::OP_BEQ, 5'd1, 5'd3, 16'd6));
    // forward to word 8
    progQ.push_back(iInstr(mipsPkg::OP_BEQ, 5'd1, 5'd2, 16'd3));
    progQ.push_back(rInstr(mipsPkg::FN_ADD, 5'd4, 5'd1, 5'd3));
    progQ.push_back(iInstr(mipsPkg::OP_BEQ, 5'd0, 5'd0, 16'd3));
    progQ.push_back(rInstr(mipsPkg::FN_ADD, 5'd5, 5'd1, 5'd1));
    progQ.push_back(rInstr(mipsPkg::FN_ADD, 5'd6, 5'd1, 5'd3));
    // back to word 5, offset -5
    progQ.push_back(iInstr(mipsPkg::OP_BEQ, 5'd6, 5'd6, 16'hfffb));
    progQ.push_back(rInstr(mipsPkg::FN_ADD, 5'd7, 5'd2, 5'd3));
    runProgram(2 * progQ.size() + 8);
  endtask

  task automatic jumps();
    newImage();
    dataInit[0] = $random(seed);
    progQ.push_back(iInstr(mipsPkg::OP_LW, 5'd0, 5'd1, 16'd0));
    progQ.push_back(jInstr(mipsPkg::OP_J, 26'd4));
    progQ.push_back(rInstr(mipsPkg::FN_ADD, 5'd2, 5'd1, 5'd1));
    progQ.push_back(rInstr(mipsPkg::FN_ADD, 5'd3, 5'd1, 5'd1));
    // link value 0x14 into r31
    progQ.push_back(jInstr(mipsPkg::OP_JAL, 26'd7));
    progQ.push_back(rInstr(mipsPkg::FN_ADD, 5'd4, 5'd1, 5'd1));
    progQ.push_back(jInstr(mipsPkg::OP_J, 26'd9));
    progQ.push_back(rInstr(mipsPkg::FN_ADD, 5'd5, 5'd31, 5'd0));
    progQ.push_back(iInstr(mipsPkg::OP_SW, 5'd0, 5'd31, 16'd8));
    runProgram(2 * progQ.size() + 8);
  endtask

  task automatic zeroRegAndNop();
    newImage();
    dataInit[0] = $random(seed);
    progQ.push_back(iInstr(mipsPkg::OP_LW, 5'd0, 5'd1, 16'd0));
    progQ.push_back(rInstr(mipsPkg::FN_ADD, 5'd0, 5'd1, 5'd1));
    progQ.push_back(rInstr(mipsPkg::FN_ADD, 5'd2, 5'd0, 5'd1));
    // unknown opcode, then unknown funct
    progQ.push_back({6'h3e, 5'd1, 5'd2, 16'h1234});
    progQ.push_back(rInstr(6'h3f, 5'd3, 5'd1, 5'd1));
    progQ.push_back(rInstr(mipsPkg::FN_OR, 5'd4, 5'd0, 5'd0));
    progQ.push_back(iInstr(mipsPkg::OP_SW, 5'd0, 5'd0, 16'd12));
    runProgram(2 * progQ.size() + 8);
  endtask

  initial begin
    seed    = 32'h9031;
    rst     = 1'b0;
    loadNow = 1'b0;
    arithmeticOps();
    loadStore();
    branches();
    jumps();
    zeroRegAndNop();
    if (i_singleCycleMips.i_singleCycleMips_assertions.failCount == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "assertion failed");
    end
  end

endmodule

// File: singleCycleMips.f
+incdir+rtl
rtl/mipsPkg.sv
rtl/mainDecoder.sv
rtl/regFile.sv
rtl/alu.sv
rtl/pcUnit.sv
rtl/singleCycleMips.sv
test/singleCycleMips_assertions.sv
test/singleCycleMipsTb.sv

// File: Bender.yml
package:
  name: singleCycleMips

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mipsPkg.sv
      - rtl/mainDecoder.sv
      - rtl/regFile.sv
      - rtl/alu.sv
      - rtl/pcUnit.sv
      - rtl/singleCycleMips.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/singleCycleMips_assertions.sv
      - test/singleCycleMipsTb.sv
